/* hdl/fetch_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch front end shared definitions.
// Widths, RISC-V major opcodes for the scan, and the command, message
// and scan class encodings.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package fetch_pkg;

  localparam int instr_width_gp = 32;
  localparam int vaddr_width_gp = 32;

  // Major opcodes, instr[6:0].
  localparam logic [6:0] opc_branch_gc = 7'b1100011;
  localparam logic [6:0] opc_jal_gc    = 7'b1101111;
  localparam logic [6:0] opc_jalr_gc   = 7'b1100111;

  typedef enum logic [1:0]
  {
    e_op_redirect = 2'd0
    , e_op_halt   = 2'd1
    , e_op_resume = 2'd2
  } fe_cmd_op_e;

  typedef enum logic [1:0]
  {
    e_msg_fetch          = 2'd0
    , e_msg_access_fault = 2'd1
    , e_msg_misaligned   = 2'd2
  } fe_msg_e;

  typedef enum logic [1:0]
  {
    e_scan_other    = 2'd0
    , e_scan_branch = 2'd1
    , e_scan_jal    = 2'd2
    , e_scan_jalr   = 2'd3
  } fe_scan_e;

endpackage

/* hdl/fetch_stage.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch stage.
// Holds the PC and run state, reads the local instruction memory one
// word per cycle and flags misaligned or out of range fetches.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module fetch_stage
  #(parameter int imem_words_p = 64
    , localparam int imem_addr_width_lp = $clog2(imem_words_p)
    )
  (input                                         clk_i
   , input                                       rst_i

   , input                                       fe_cmd_v_i
   , input fetch_pkg::fe_cmd_op_e                fe_cmd_op_i
   , input [fetch_pkg::vaddr_width_gp-1:0]       fe_cmd_pc_i
   , output logic                                fe_cmd_yumi_o

   , input                                       imem_w_v_i
   , input [imem_addr_width_lp-1:0]              imem_w_addr_i
   , input [fetch_pkg::instr_width_gp-1:0]       imem_w_data_i

   , input                                       space_i
   , output logic                                enq_v_o
   , output logic [fetch_pkg::vaddr_width_gp-1:0] enq_pc_o
   , output logic [fetch_pkg::instr_width_gp-1:0] enq_instr_o
   , output fetch_pkg::fe_msg_e                  enq_fault_o
   , output logic                                flush_o
   );

  import fetch_pkg::*;

  logic [instr_width_gp-1:0] mem [imem_words_p];

  logic run_r, run_n;
  logic [vaddr_width_gp-1:0] pc_r;
  logic rd_v_r;
  logic [vaddr_width_gp-1:0] rd_pc_r;
  logic [instr_width_gp-1:0] rd_instr_r;
  fe_msg_e rd_fault_r;

  logic is_redirect, is_halt, is_resume;
  logic issue;
  logic [vaddr_width_gp-1:0] fetch_pc;
  logic [imem_addr_width_lp-1:0] fetch_idx;
  fe_msg_e fetch_fault;

  assign fe_cmd_yumi_o = fe_cmd_v_i & ~rst_i;  // Commands never wait.
  assign is_redirect = fe_cmd_yumi_o & (fe_cmd_op_i == e_op_redirect);
  assign is_halt = fe_cmd_yumi_o & (fe_cmd_op_i == e_op_halt);
  assign is_resume = fe_cmd_yumi_o & (fe_cmd_op_i == e_op_resume);
  assign flush_o = is_redirect | is_halt;

  always_comb
  begin
    run_n = run_r;
    fetch_pc = pc_r;
    issue = run_r & space_i;
    if (is_redirect)
    begin
      run_n = 1'b1;
      fetch_pc = fe_cmd_pc_i;
      issue = 1'b1;  // Queue empties on this same edge.
    end
    else if (is_halt)
    begin
      run_n = 1'b0;
      issue = 1'b0;
    end
    else if (is_resume)
    begin
      run_n = 1'b1;
      issue = space_i;
    end
  end

  assign fetch_idx = fetch_pc[imem_addr_width_lp+1:2];

  always_comb
  begin
    if (fetch_pc[1:0] != 2'b00)
      fetch_fault = e_msg_misaligned;
    else if (fetch_pc[vaddr_width_gp-1:2] >= (vaddr_width_gp-2)'(imem_words_p))
      fetch_fault = e_msg_access_fault;
    else
      fetch_fault = e_msg_fetch;
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      run_r <= 1'b0;
      pc_r <= '0;
      rd_v_r <= 1'b0;
    end
    else
    begin
      rd_v_r <= issue;
      if (issue && (fetch_fault != e_msg_fetch))
      begin
        run_r <= 1'b0;  // Faulting word is the last one.
        pc_r <= fetch_pc;
      end
      else
      begin
        run_r <= run_n;
        pc_r <= issue ? fetch_pc + vaddr_width_gp'(4) : fetch_pc;
      end
    end
  end

  // Load port, only used while halted.
  always_ff @(posedge clk_i)
  begin
    if (imem_w_v_i)
      mem[imem_w_addr_i] <= imem_w_data_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (issue)
    begin
      rd_pc_r <= fetch_pc;
      rd_instr_r <= mem[fetch_idx];
      rd_fault_r <= fetch_fault;
    end
  end

  assign enq_v_o = rd_v_r;
  assign enq_pc_o = rd_pc_r;
  assign enq_instr_o = (rd_fault_r == e_msg_fetch) ? rd_instr_r : '0;
  assign enq_fault_o = rd_fault_r;

endmodule

/* hdl/fetch_queue.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch queue.
// Circular FIFO of fetched words with flush; space looks one entry
// ahead so the word already being read always has a slot.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module fetch_queue
  #(parameter int queue_depth_p = 4
    , localparam int ptr_width_lp = $clog2(queue_depth_p)
    , localparam int count_width_lp = $clog2(queue_depth_p+1)
    )
  (input                                         clk_i
   , input                                       rst_i
   , input                                       flush_i

   , input                                       enq_v_i
   , input [fetch_pkg::vaddr_width_gp-1:0]       enq_pc_i
   , input [fetch_pkg::instr_width_gp-1:0]       enq_instr_i
   , input fetch_pkg::fe_msg_e                   enq_fault_i
   , output logic                                space_o

   , output logic                                deq_v_o
   , output logic [fetch_pkg::vaddr_width_gp-1:0] deq_pc_o
   , output logic [fetch_pkg::instr_width_gp-1:0] deq_instr_o
   , output fetch_pkg::fe_msg_e                  deq_msg_o
   , input                                       deq_yumi_i
   );

  import fetch_pkg::*;

  logic [vaddr_width_gp-1:0] pc_mem [queue_depth_p];
  logic [instr_width_gp-1:0] instr_mem [queue_depth_p];
  fe_msg_e msg_mem [queue_depth_p];

  logic [ptr_width_lp-1:0] wr_ptr_r, rd_ptr_r;
  logic [count_width_lp-1:0] count_r;
  logic enq, deq;

  // Flush wins over both ports; it also drops the word in flight.
  assign enq = enq_v_i & ~flush_i & (count_r != count_width_lp'(queue_depth_p));
  assign deq = deq_yumi_i & ~flush_i;

  assign space_o = (count_r <= count_width_lp'(queue_depth_p - 2));
  assign deq_v_o = (count_r != '0);

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r <= '0;
    end
    else if (flush_i)
    begin
      rd_ptr_r <= wr_ptr_r;
      count_r <= '0;
    end
    else
    begin
      if (enq)
        wr_ptr_r <= wr_ptr_r + 1'b1;
      if (deq)
        rd_ptr_r <= rd_ptr_r + 1'b1;
      case ({enq, deq})
        2'b10: count_r <= count_r + 1'b1;
        2'b01: count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (enq)
    begin
      pc_mem[wr_ptr_r] <= enq_pc_i;
      instr_mem[wr_ptr_r] <= enq_instr_i;
      msg_mem[wr_ptr_r] <= enq_fault_i;
    end
  end

  assign deq_pc_o = pc_mem[rd_ptr_r];  // Head read straight from storage.
  assign deq_instr_o = instr_mem[rd_ptr_r];
  assign deq_msg_o = msg_mem[rd_ptr_r];

endmodule

/* hdl/fetch_msg_former.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Queue message former.
// Scans the head word for control flow class and drives the
// valid/ready_and queue port toward the back end.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module fetch_msg_former
  (input                                         deq_v_i
   , input [fetch_pkg::vaddr_width_gp-1:0]       deq_pc_i
   , input [fetch_pkg::instr_width_gp-1:0]       deq_instr_i
   , input fetch_pkg::fe_msg_e                   deq_msg_i
   , output logic                                deq_yumi_o

   , output logic                                fe_queue_v_o
   , output logic [fetch_pkg::vaddr_width_gp-1:0] fe_queue_pc_o
   , output logic [fetch_pkg::instr_width_gp-1:0] fe_queue_instr_o
   , output fetch_pkg::fe_msg_e                  fe_queue_msg_o
   , output fetch_pkg::fe_scan_e                 fe_queue_scan_o
   , input                                       fe_queue_ready_and_i
   );

  import fetch_pkg::*;

  logic [6:0] opcode;
  fe_scan_e scan;

  assign opcode = deq_instr_i[6:0];

  always_comb
  begin
    case (opcode)
      opc_branch_gc: scan = e_scan_branch;
      opc_jal_gc: scan = e_scan_jal;
      opc_jalr_gc: scan = e_scan_jalr;
      default: scan = e_scan_other;
    endcase
  end

  assign fe_queue_v_o = deq_v_i;
  assign fe_queue_pc_o = deq_pc_i;
  assign fe_queue_instr_o = deq_instr_i;
  assign fe_queue_msg_o = deq_msg_i;
  // Fault messages carry a zero word, never a real class.
  assign fe_queue_scan_o = (deq_msg_i == e_msg_fetch) ? scan : e_scan_other;

  assign deq_yumi_o = deq_v_i & fe_queue_ready_and_i;

endmodule

/* hdl/fetch_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction fetch front end, top level.
// Fetch stage, fetch queue and message former between the back end
// command port and the fetch queue port.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module fetch_unit
  #(parameter int imem_words_p = 64
    , parameter int queue_depth_p = 4
    , localparam int imem_addr_width_lp = $clog2(imem_words_p)
    )
  (input                                         clk_i
   , input                                       rst_i

   , input                                       fe_cmd_v_i
   , input fetch_pkg::fe_cmd_op_e                fe_cmd_op_i
   , input [fetch_pkg::vaddr_width_gp-1:0]       fe_cmd_pc_i
   , output logic                                fe_cmd_yumi_o

   , input                                       imem_w_v_i
   , input [imem_addr_width_lp-1:0]              imem_w_addr_i
   , input [fetch_pkg::instr_width_gp-1:0]       imem_w_data_i

   , output logic                                fe_queue_v_o
   , output logic [fetch_pkg::vaddr_width_gp-1:0] fe_queue_pc_o
   , output logic [fetch_pkg::instr_width_gp-1:0] fe_queue_instr_o
   , output fetch_pkg::fe_msg_e                  fe_queue_msg_o
   , output fetch_pkg::fe_scan_e                 fe_queue_scan_o
   , input                                       fe_queue_ready_and_i
   );

  import fetch_pkg::*;

  logic enq_v, flush, space;
  logic [vaddr_width_gp-1:0] enq_pc;
  logic [instr_width_gp-1:0] enq_instr;
  fe_msg_e enq_fault;

  logic deq_v, deq_yumi;
  logic [vaddr_width_gp-1:0] deq_pc;
  logic [instr_width_gp-1:0] deq_instr;
  fe_msg_e deq_msg;

  fetch_stage
   #(.imem_words_p(imem_words_p))
   stage0
    (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.fe_cmd_v_i(fe_cmd_v_i)
     ,.fe_cmd_op_i(fe_cmd_op_i)
     ,.fe_cmd_pc_i(fe_cmd_pc_i)
     ,.fe_cmd_yumi_o(fe_cmd_yumi_o)
     ,.imem_w_v_i(imem_w_v_i)
     ,.imem_w_addr_i(imem_w_addr_i)
     ,.imem_w_data_i(imem_w_data_i)
     ,.space_i(space)
     ,.enq_v_o(enq_v)
     ,.enq_pc_o(enq_pc)
     ,.enq_instr_o(enq_instr)
     ,.enq_fault_o(enq_fault)
     ,.flush_o(flush)
     );

  fetch_queue
   #(.queue_depth_p(queue_depth_p))
   queue0
    (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.flush_i(flush)
     ,.enq_v_i(enq_v)
     ,.enq_pc_i(enq_pc)
     ,.enq_instr_i(enq_instr)
     ,.enq_fault_i(enq_fault)
     ,.space_o(space)
     ,.deq_v_o(deq_v)
     ,.deq_pc_o(deq_pc)
     ,.deq_instr_o(deq_instr)
     ,.deq_msg_o(deq_msg)
     ,.deq_yumi_i(deq_yumi)
     );

  fetch_msg_former
   former0
    (.deq_v_i(deq_v)
     ,.deq_pc_i(deq_pc)
     ,.deq_instr_i(deq_instr)
     ,.deq_msg_i(deq_msg)
     ,.deq_yumi_o(deq_yumi)
     ,.fe_queue_v_o(fe_queue_v_o)
     ,.fe_queue_pc_o(fe_queue_pc_o)
     ,.fe_queue_instr_o(fe_queue_instr_o)
     ,.fe_queue_msg_o(fe_queue_msg_o)
     ,.fe_queue_scan_o(fe_queue_scan_o)
     ,.fe_queue_ready_and_i(fe_queue_ready_and_i)
     );

endmodule

/* verification/fetch_unit_sva.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch unit assertions.
// Command handshake, queue port payload stability and flush behavior.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module fetch_unit_sva
  (input                                   clk_i
   , input                                 rst_i
   , input                                 fe_cmd_v_i
   , input                                 fe_cmd_yumi_i
   , input                                 flush_i
   , input                                 fe_queue_v_i
   , input                                 fe_queue_ready_and_i
   , input [fetch_pkg::vaddr_width_gp-1:0] fe_queue_pc_i
   , input [fetch_pkg::instr_width_gp-1:0] fe_queue_instr_i
   , input [1:0]                           fe_queue_msg_i
   );

  timeunit 1ns;
  timeprecision 100ps;

  yumi_follows_v: assert property (@(posedge clk_i)
    fe_cmd_yumi_i == (fe_cmd_v_i && !rst_i))
    else $error("Command yumi does not follow command valid.");

  // A stalled message must stay put unless a flush drops it.
  payload_holds: assert property (@(posedge clk_i) disable iff (rst_i)
    fe_queue_v_i && !fe_queue_ready_and_i && !flush_i
    |=> fe_queue_v_i && $stable(fe_queue_pc_i) && $stable(fe_queue_instr_i)
        && $stable(fe_queue_msg_i))
    else $error("Queue port payload changed while stalled.");

  flush_empties: assert property (@(posedge clk_i) disable iff (rst_i)
    flush_i |=> !fe_queue_v_i)
    else $error("Queue port still valid after a flush.");

  reset_empties: assert property (@(posedge clk_i) rst_i |=> !fe_queue_v_i)
    else $error("Queue port valid out of reset.");

endmodule

bind fetch_unit fetch_unit_sva sva0
  (.clk_i(clk_i)
   ,.rst_i(rst_i)
   ,.fe_cmd_v_i(fe_cmd_v_i)
   ,.fe_cmd_yumi_i(fe_cmd_yumi_o)
   ,.flush_i(flush)
   ,.fe_queue_v_i(fe_queue_v_o)
   ,.fe_queue_ready_and_i(fe_queue_ready_and_i)
   ,.fe_queue_pc_i(fe_queue_pc_o)
   ,.fe_queue_instr_i(fe_queue_instr_o)
   ,.fe_queue_msg_i(fe_queue_msg_o)
   );

/* verification/tb_fetch_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch unit testbench.
// Loads memory, issues commands from the test records and checks the
// messages seen at the queue port under varying back-pressure.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_fetch_unit;

  timeunit 1ns;
  timeprecision 100ps;

  import fetch_pkg::*;

  localparam int imem_words_lp = 64;
  localparam int queue_depth_lp = 4;
  localparam int quiet_cycles_lp = 12;  // Idle window that must stay silent.
  localparam string tests_file_lp = "verification/fetch_unit_tests.txt";

  logic clk, rst;
  logic fe_cmd_v, fe_cmd_yumi;
  fe_cmd_op_e fe_cmd_op;
  logic [vaddr_width_gp-1:0] fe_cmd_pc;
  logic imem_w_v;
  logic [$clog2(imem_words_lp)-1:0] imem_w_addr;
  logic [instr_width_gp-1:0] imem_w_data;
  logic fe_queue_v, fe_queue_ready_and;
  logic [vaddr_width_gp-1:0] fe_queue_pc;
  logic [instr_width_gp-1:0] fe_queue_instr;
  fe_msg_e fe_queue_msg;
  fe_scan_e fe_queue_scan;

  int wr_test_q[$];
  logic [31:0] wr_addr_q[$], wr_data_q[$];
  int cmd_op_q[$], cmd_ready_q[$], cmd_count_q[$], cmd_first_q[$];
  logic [31:0] cmd_pc_q[$];
  logic [31:0] exp_pc_q[$], exp_instr_q[$], exp_msg_q[$], exp_scan_q[$];
  logic [31:0] got_pc_q[$], got_instr_q[$], got_msg_q[$], got_scan_q[$];

  integer seed = 32'hbb42_4c66;
  int ready_mode = 3;  // 0 always, 1 random, 2 never, 3 low.
  int errors = 0;
  int test_errors = 0;
  int passed = 0;
  int failed = 0;
  int cycles = 0;
  int cycle_limit = 0;

  fetch_unit
   #(.imem_words_p(imem_words_lp)
     ,.queue_depth_p(queue_depth_lp))
   dut0
    (.clk_i(clk)
     ,.rst_i(rst)
     ,.fe_cmd_v_i(fe_cmd_v)
     ,.fe_cmd_op_i(fe_cmd_op)
     ,.fe_cmd_pc_i(fe_cmd_pc)
     ,.fe_cmd_yumi_o(fe_cmd_yumi)
     ,.imem_w_v_i(imem_w_v)
     ,.imem_w_addr_i(imem_w_addr)
     ,.imem_w_data_i(imem_w_data)
     ,.fe_queue_v_o(fe_queue_v)
     ,.fe_queue_pc_o(fe_queue_pc)
     ,.fe_queue_instr_o(fe_queue_instr)
     ,.fe_queue_msg_o(fe_queue_msg)
     ,.fe_queue_scan_o(fe_queue_scan)
     ,.fe_queue_ready_and_i(fe_queue_ready_and)
     );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit)
    begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  task automatic load_tests(output bit ok);
    int fd;
    int n;
    string line;
    logic [31:0] a, b, c, d;
    ok = 1'b0;
    fd = $fopen(tests_file_lp, "r");
    if (fd != 0)
    begin
      while (!$feof(fd))
      begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0)
        begin
          case (line.getc(0))
            "W":
            begin
              n = $sscanf(line, "W %h %h", a, b);
              wr_test_q.push_back(cmd_op_q.size());  // Belongs to the next command.
              wr_addr_q.push_back(a);
              wr_data_q.push_back(b);
            end
            "C":
            begin
              n = $sscanf(line, "C %d %h %d %d", a, b, c, d);
              cmd_op_q.push_back(a);
              cmd_pc_q.push_back(b);
              cmd_ready_q.push_back(c);
              cmd_count_q.push_back(d);
              cmd_first_q.push_back(exp_pc_q.size());
            end
            "E":
            begin
              n = $sscanf(line, "E %h %h %d %d", a, b, c, d);
              exp_pc_q.push_back(a);
              exp_instr_q.push_back(b);
              exp_msg_q.push_back(c);
              exp_scan_q.push_back(d);
            end
            default: ;  // Comments and blank lines.
          endcase
        end
      end
      $fclose(fd);
      ok = (cmd_op_q.size() > 0);
    end
  endtask

  task automatic check_value(input string field, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, field, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  // Advance to the falling edge, drive ready and log a transfer for the next rising edge.
  task automatic tick();
    @(negedge clk);
    case (ready_mode)
      0: fe_queue_ready_and = 1'b1;
      1: fe_queue_ready_and = 1'($random(seed));
      default: fe_queue_ready_and = 1'b0;
    endcase
    if (fe_queue_v && fe_queue_ready_and)
    begin
      got_pc_q.push_back(fe_queue_pc);
      got_instr_q.push_back(fe_queue_instr);
      got_msg_q.push_back(32'(fe_queue_msg));
      got_scan_q.push_back(32'(fe_queue_scan));
    end
  endtask

  task automatic run_test(input int t);
    int first;
    int count;
    first = cmd_first_q[t];
    count = cmd_count_q[t];
    test_errors = 0;
    got_pc_q.delete();
    got_instr_q.delete();
    got_msg_q.delete();
    got_scan_q.delete();
    ready_mode = 3;
    for (int k = 0; k < wr_test_q.size(); k++)
    begin
      if (wr_test_q[k] == t)
      begin
        tick();
        imem_w_v = 1'b1;
        imem_w_addr = $bits(imem_w_addr)'(wr_addr_q[k] >> 2);
        imem_w_data = wr_data_q[k];
      end
    end
    tick();
    imem_w_v = 1'b0;
    fe_cmd_v = 1'b1;
    fe_cmd_op = fe_cmd_op_e'(cmd_op_q[t]);
    fe_cmd_pc = cmd_pc_q[t];
    ready_mode = cmd_ready_q[t];
    tick();  // Ready is low in the command cycle.
    check_value("command yumi", 32'(fe_cmd_yumi), 32'd1);
    fe_cmd_v = 1'b0;
    while (got_pc_q.size() < count)
      tick();
    repeat (quiet_cycles_lp)
      tick();
    check_value("message count", got_pc_q.size(), count);
    if (cmd_ready_q[t] == 2 && cmd_op_q[t] == 0)
    begin
      // Nothing drains, so the redirect target sits at the head.
      check_value("held valid", 32'(fe_queue_v), 32'd1);
      check_value("held pc", fe_queue_pc, cmd_pc_q[t]);
    end
    for (int i = 0; i < count && i < got_pc_q.size(); i++)
    begin
      check_value("pc", got_pc_q[i], exp_pc_q[first+i]);
      check_value("instr", got_instr_q[i], exp_instr_q[first+i]);
      check_value("msg", got_msg_q[i], exp_msg_q[first+i]);
      check_value("scan", got_scan_q[i], exp_scan_q[first+i]);
    end
    if (test_errors == 0)
    begin
      passed++;
      $display("Test %0d passed with %0d messages", t + 1, count);
    end
    else
    begin
      failed++;
      $display("Test %0d failed with %0d errors", t + 1, test_errors);
    end
  endtask

  initial
  begin
    bit loaded;
    rst = 1'b1;
    fe_cmd_v = 1'b0;
    fe_cmd_op = e_op_redirect;
    fe_cmd_pc = '0;
    imem_w_v = 1'b0;
    imem_w_addr = '0;
    imem_w_data = '0;
    fe_queue_ready_and = 1'b0;
    load_tests(loaded);
    if (!loaded)
    begin
      $display("The test file %s could not be read", tests_file_lp);
      $display("STATUS: FAIL");
      $finish;
    end
    else
    begin
      cycle_limit = 40 * exp_pc_q.size() + 200;
      repeat (5) @(negedge clk);
      rst = 1'b0;
      for (int t = 0; t < cmd_op_q.size(); t++)
        run_test(t);
      $display("Tests run %0d, passed %0d, failed %0d", cmd_op_q.size(), passed, failed);
      if (errors == 0 && failed == 0)
        $display("STATUS: PASS");
      else
        $display("STATUS: FAIL");
      $finish;
    end
  end

endmodule

/* fetch_unit.f */
hdl/fetch_pkg.sv
hdl/fetch_stage.sv
hdl/fetch_queue.sv
hdl/fetch_msg_former.sv
hdl/fetch_unit.sv
verification/fetch_unit_sva.sv
verification/tb_fetch_unit.sv

/* Makefile */
TOOL       = verilator
TOP        = tb_fetch_unit
FLIST      = fetch_unit.f
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
BUILD      = obj_dir
LOG        = sim.log
PASS_LINE  = STATUS: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_LINE)" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

/* verification/fetch_unit_tests.txt */
# W addr data: memory write, byte address and word in hex.
# C op pc ready count: op 0 redirect 1 halt 2 resume, pc in hex,
#   ready 0 always 1 random 2 never, expected message count.
# E pc instr msg scan: msg 0 fetch 1 access fault 2 misaligned, scan 0 other 1 branch 2 jal 3 jalr.
W 0f0 00208463
W 0f4 008000ef
W 0f8 00008067
W 0fc 00500093
C 0 000000f0 0 5
E 000000f0 00208463 0 1
E 000000f4 008000ef 0 2
E 000000f8 00008067 0 3
E 000000fc 00500093 0 0
E 00000100 00000000 1 0
C 0 000000f0 1 5
E 000000f0 00208463 0 1
E 000000f4 008000ef 0 2
E 000000f8 00008067 0 3
E 000000fc 00500093 0 0
E 00000100 00000000 1 0
C 0 00000042 0 1
E 00000042 00000000 2 0
C 0 000000c0 2 0
C 0 000000f0 0 5
E 000000f0 00208463 0 1
E 000000f4 008000ef 0 2
E 000000f8 00008067 0 3
E 000000fc 00500093 0 0
E 00000100 00000000 1 0
C 0 000000e0 2 0
C 1 00000000 0 0
C 2 00000000 0 5
E 000000f0 00208463 0 1
E 000000f4 008000ef 0 2
E 000000f8 00008067 0 3
E 000000fc 00500093 0 0
E 00000100 00000000 1 0
